// ==== src/copper_pkg.sv ====
// copper opcodes, instruction views and union, bank fill constants
package copper_pkg;

    // 2-bit opcode, sits at bits [17:16] of every instruction
    typedef enum logic [1:0] {
        OP_WAIT = 2'd0,
        OP_MOVE = 2'd1,
        // reserved code, the engine treats it as end of program
        OP_RSVD = 2'd2,
        OP_END  = 2'd3
    } cop_op_e;

    // wait view: hold until the beam passes line v_pos, pixel h_pos
    typedef struct packed {
        // target line, zero extended against v_count
        logic [13:0] v_pos;
        cop_op_e     op;
        // target pixel
        logic [15:0] h_pos;
    } cop_wait_t;

    // move view: one register write of data to reg_addr
    typedef struct packed {
        // only the low REG_AW bits leave the engine
        logic [13:0] reg_addr;
        cop_op_e     op;
        logic [15:0] data;
    } cop_move_t;

    // one 32-bit instruction word
    // upper half from the odd bank, lower half from the even bank
    // op lands on the same bits in both views
    typedef union packed {
        cop_wait_t w;
        cop_move_t m;
    } cop_instr_u;

    // power-up bank contents
    // odd word 16'h0003 puts OP_END in the op field, even word is don't care
    localparam logic [15:0] EVEN_FILL = 16'h0000;
    localparam logic [15:0] ODD_FILL  = 16'h0003;

endpackage

// ==== src/copper_mem.sv ====
// one 16-bit bank of copper program memory with parity-claimed host writes
`timescale 1ns/1ns

module copper_mem #(
    parameter int ADDR_W   = 10,
    parameter int ODD_WORD = 0
) (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              host_wr_i,
    input  logic [ADDR_W:0]   host_addr_i,
    input  logic [15:0]       host_data_i,
    input  logic              rd_en_i,
    input  logic [ADDR_W-1:0] rd_addr_i,
    output logic [15:0]       rd_data_o
);

    localparam int      DEPTH    = 2 ** ADDR_W;
    // host address bit 0 that this bank answers to
    localparam logic    BANK_SEL = (ODD_WORD != 0);
    localparam logic [15:0] FILL = (ODD_WORD != 0) ? copper_pkg::ODD_FILL
                                                   : copper_pkg::EVEN_FILL;

    // one half of every 32-bit instruction by instruction number
    logic [15:0] mem [0:DEPTH-1];

    logic wr_hit;

    // only the bank with matching word parity takes the write
    assign wr_hit = host_wr_i && (host_addr_i[0] == BANK_SEL);

    // unwritten program decodes as END
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = FILL;
        end
    end

    // upper address bits pick the instruction slot on a write
    always_ff @(posedge clk) begin
        if (wr_hit) begin
            mem[host_addr_i[ADDR_W:1]] <= host_data_i;
        end
    end

    // registered read where the old word wins on a same-cycle write
    // output holds while rd_en_i is low
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            rd_data_o <= mem[rd_addr_i];
        end
    end

    // host must present a clean address with every write strobe
    a_host_addr_known : assert property (@(posedge clk) disable iff (!rst_n_i)
        host_wr_i |-> !$isunknown(host_addr_i));

endmodule

// ==== src/copper_engine.sv ====
// fetch, decode and execute FSM joining bank words into register writes
`timescale 1ns/1ns

module copper_engine #(
    parameter int ADDR_W = 10,
    // must not exceed the 14-bit reg_addr field
    parameter int REG_AW = 8
) (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              frame_start_i,
    input  logic [15:0]       h_count_i,
    input  logic [15:0]       v_count_i,
    output logic              fetch_en_o,
    output logic [ADDR_W-1:0] fetch_addr_o,
    input  logic [15:0]       even_word_i,
    input  logic [15:0]       odd_word_i,
    output logic              reg_wr_o,
    output logic [REG_AW-1:0] reg_addr_o,
    output logic [15:0]       reg_data_o,
    output logic              busy_o
);

    // engine states
    localparam logic [2:0] ST_IDLE   = 3'd0;
    localparam logic [2:0] ST_FETCH  = 3'd1;
    localparam logic [2:0] ST_DECODE = 3'd2;
    localparam logic [2:0] ST_WAIT   = 3'd3;
    localparam logic [2:0] ST_EXEC   = 3'd4;

    logic [2:0]             state_q;
    // index of the instruction being worked on
    logic [ADDR_W-1:0]      index_q;
    copper_pkg::cop_instr_u instr;
    logic                   beam_reached;
    logic                   index_last;
    logic [2:0]             state_adv;

    // bank outputs only change after a fetch, so the joined word
    // stays stable through DECODE, WAIT and EXEC
    assign instr = {odd_word_i, even_word_i};

    // beam is past the target line or on it at or past the target pixel
    assign beam_reached = (v_count_i > {2'b00, instr.w.v_pos}) ||
                          ((v_count_i == {2'b00, instr.w.v_pos}) &&
                           (h_count_i >= instr.w.h_pos));

    // running off the end of memory acts like END
    assign index_last = &index_q;
    assign state_adv  = index_last ? ST_IDLE : ST_FETCH;

    // both banks read the same instruction slot
    assign fetch_addr_o = index_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q    <= ST_IDLE;
            index_q    <= '0;
            reg_wr_o   <= 1'b0;
            fetch_en_o <= 1'b0;
            busy_o     <= 1'b0;
        end else begin
            // strobes are one cycle wide
            reg_wr_o   <= 1'b0;
            fetch_en_o <= 1'b0;
            if (frame_start_i) begin
                // restart from the top from any state
                // a move in EXEC is dropped
                state_q    <= ST_FETCH;
                index_q    <= '0;
                fetch_en_o <= 1'b1;
                busy_o     <= 1'b1;
            end else begin
                case (state_q)
                    ST_FETCH: begin
                        // bank words arrive on the next edge
                        state_q <= ST_DECODE;
                    end
                    ST_DECODE: begin
                        case (instr.w.op)
                            copper_pkg::OP_WAIT: state_q <= ST_WAIT;
                            copper_pkg::OP_MOVE: state_q <= ST_EXEC;
                            // END and the reserved code both halt
                            default: begin
                                state_q <= ST_IDLE;
                                busy_o  <= 1'b0;
                            end
                        endcase
                    end
                    ST_WAIT: begin
                        if (beam_reached) begin
                            state_q    <= state_adv;
                            index_q    <= index_q + 1'b1;
                            fetch_en_o <= !index_last;
                            busy_o     <= !index_last;
                        end
                    end
                    ST_EXEC: begin
                        reg_wr_o   <= 1'b1;
                        state_q    <= state_adv;
                        index_q    <= index_q + 1'b1;
                        fetch_en_o <= !index_last;
                    end
                    default: begin
                        // idle until the next frame start
                        // busy stays up through the strobe of a final move
                        state_q <= ST_IDLE;
                        busy_o  <= 1'b0;
                    end
                endcase
            end
        end
    end

    // move payload taken from the move view together with the strobe
    always_ff @(posedge clk) begin
        if (state_q == ST_EXEC) begin
            reg_addr_o <= instr.m.reg_addr[REG_AW-1:0];
            reg_data_o <= instr.m.data;
        end
    end

    // each move gives one strobe and never two in a row
    a_reg_wr_single : assert property (@(posedge clk) disable iff (!rst_n_i)
        reg_wr_o |=> !reg_wr_o);

    // no register write outside a program run
    a_reg_wr_busy : assert property (@(posedge clk) disable iff (!rst_n_i)
        !(reg_wr_o && !busy_o));

    // memory is left alone while idle
    a_idle_no_fetch : assert property (@(posedge clk) disable iff (!rst_n_i)
        (state_q == ST_IDLE) |-> !fetch_en_o);

endmodule

// ==== src/copper_top.sv ====
// even bank, odd bank and engine of the copper coprocessor
`timescale 1ns/1ns

module copper_top #(
    // word address width of one bank
    parameter int ADDR_W = 10,
    // register address bits that reach the register port
    parameter int REG_AW = 8
) (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              host_wr_i,
    input  logic [ADDR_W:0]   host_addr_i,
    input  logic [15:0]       host_data_i,
    input  logic              frame_start_i,
    input  logic [15:0]       h_count_i,
    input  logic [15:0]       v_count_i,
    output logic              reg_wr_o,
    output logic [REG_AW-1:0] reg_addr_o,
    output logic [15:0]       reg_data_o,
    output logic              busy_o
);

    // shared fetch request to both banks
    logic              fetch_en;
    logic [ADDR_W-1:0] fetch_addr;
    // low and high halves of the fetched instruction
    logic [15:0]       even_word;
    logic [15:0]       odd_word;

    // even host addresses hold the low half of each instruction
    copper_mem #(
        .ADDR_W   (ADDR_W),
        .ODD_WORD (0)
    ) i_even_mem (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .host_wr_i   (host_wr_i),
        .host_addr_i (host_addr_i),
        .host_data_i (host_data_i),
        .rd_en_i     (fetch_en),
        .rd_addr_i   (fetch_addr),
        .rd_data_o   (even_word)
    );

    // odd host addresses hold the high half with the opcode
    copper_mem #(
        .ADDR_W   (ADDR_W),
        .ODD_WORD (1)
    ) i_odd_mem (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .host_wr_i   (host_wr_i),
        .host_addr_i (host_addr_i),
        .host_data_i (host_data_i),
        .rd_en_i     (fetch_en),
        .rd_addr_i   (fetch_addr),
        .rd_data_o   (odd_word)
    );

    copper_engine #(
        .ADDR_W (ADDR_W),
        .REG_AW (REG_AW)
    ) i_engine (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .frame_start_i (frame_start_i),
        .h_count_i     (h_count_i),
        .v_count_i     (v_count_i),
        .fetch_en_o    (fetch_en),
        .fetch_addr_o  (fetch_addr),
        .even_word_i   (even_word),
        .odd_word_i    (odd_word),
        .reg_wr_o      (reg_wr_o),
        .reg_addr_o    (reg_addr_o),
        .reg_data_o    (reg_data_o),
        .busy_o        (busy_o)
    );

endmodule

// ==== verif/copper_tb.sv ====
// clock, reset, host program loads, beam sweep, timeout and checking assertions
`timescale 1ns/1ns

module copper_tb;

    localparam int ADDR_W     = 10;
    localparam int REG_AW     = 8;
    localparam int MAX_CYCLES = 4000;
    localparam int NUM_MOVES  = 8;

    logic              clk;
    logic              rst_n_i;
    logic              host_wr_i;
    logic [ADDR_W:0]   host_addr_i;
    logic [15:0]       host_data_i;
    logic              frame_start_i;
    logic [15:0]       h_count_i;
    logic [15:0]       v_count_i;
    logic              reg_wr_o;
    logic [REG_AW-1:0] reg_addr_o;
    logic [15:0]       reg_data_o;
    logic              busy_o;

    // expected register writes with head at rd_ptr and tail at wr_ptr
    logic [REG_AW-1:0] exp_addr_q [0:31];
    logic [15:0]       exp_data_q [0:31];
    int                rd_ptr = 0;
    int                wr_ptr = 0;
    logic [REG_AW-1:0] head_addr;
    logic [15:0]       head_data;

    // random move program kept for the rerun
    logic [13:0] prog_addr [0:NUM_MOVES-1];
    logic [15:0] prog_data [0:NUM_MOVES-1];

    // check enables and wait target
    logic        started    = 1'b0;
    logic        timing_chk = 1'b0;
    logic        wait_gate  = 1'b0;
    logic [13:0] wait_v     = '0;
    logic [15:0] wait_h     = '0;
    logic        beam_ok;
    int          cycle_cnt  = 0;

    copper_top #(
        .ADDR_W (ADDR_W),
        .REG_AW (REG_AW)
    ) i_dut (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .host_wr_i     (host_wr_i),
        .host_addr_i   (host_addr_i),
        .host_data_i   (host_data_i),
        .frame_start_i (frame_start_i),
        .h_count_i     (h_count_i),
        .v_count_i     (v_count_i),
        .reg_wr_o      (reg_wr_o),
        .reg_addr_o    (reg_addr_o),
        .reg_data_o    (reg_data_o),
        .busy_o        (busy_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    assign head_addr = exp_addr_q[rd_ptr];
    assign head_data = exp_data_q[rd_ptr];

    // beam past the wait target by line first and then by pixel
    assign beam_ok = (v_count_i > {2'b00, wait_v}) ||
                     ((v_count_i == {2'b00, wait_v}) && (h_count_i >= wait_h));

    // pop one expected write per strobe
    always_ff @(posedge clk) begin
        if (reg_wr_o) begin
            rd_ptr <= rd_ptr + 1;
        end
    end

    always_ff @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Test failed");
            $fatal(1);
        end
    end

    // nothing moves before the first frame start
    a_quiet_before_start : assert property (@(posedge clk) disable iff (!rst_n_i)
        !started |-> (!reg_wr_o && !busy_o))
    else begin
        $display("engine became active before the first frame start");
        $display("Test failed");
        $fatal(1);
    end

    // once idle, the engine stays idle until a frame start
    a_idle_stays_idle : assert property (@(posedge clk) disable iff (!rst_n_i)
        (!busy_o && !frame_start_i) |=> (!busy_o && !reg_wr_o))
    else begin
        $display("engine left idle without a frame start");
        $display("Test failed");
        $fatal(1);
    end

    a_wr_expected : assert property (@(posedge clk) disable iff (!rst_n_i)
        reg_wr_o |-> (rd_ptr != wr_ptr))
    else begin
        $display("register write seen when no write was expected");
        $display("Test failed");
        $fatal(1);
    end

    a_wr_addr : assert property (@(posedge clk) disable iff (!rst_n_i)
        reg_wr_o |-> (reg_addr_o == head_addr))
    else begin
        $display("FAILED reg_addr_o = %h, expected %h",
                 $sampled(reg_addr_o), $sampled(head_addr));
        $display("Test failed");
        $fatal(1);
    end

    a_wr_data : assert property (@(posedge clk) disable iff (!rst_n_i)
        reg_wr_o |-> (reg_data_o == head_data))
    else begin
        $display("FAILED reg_data_o = %h, expected %h",
                 $sampled(reg_data_o), $sampled(head_data));
        $display("Test failed");
        $fatal(1);
    end

    // strobe lands in the cycle after edge N+3
    a_first_pulse : assert property (@(posedge clk) disable iff (!rst_n_i)
        (frame_start_i && timing_chk) |-> ##4 reg_wr_o)
    else begin
        $display("first register write did not follow the frame start by 3 cycles");
        $display("Test failed");
        $fatal(1);
    end

    // back to back moves come every 3 cycles while more are queued
    a_move_spacing : assert property (@(posedge clk) disable iff (!rst_n_i)
        (reg_wr_o && timing_chk && (rd_ptr + 1 != wr_ptr)) |-> ##3 reg_wr_o)
    else begin
        $display("consecutive moves were not 3 cycles apart");
        $display("Test failed");
        $fatal(1);
    end

    // strobe at E+4 where E is the first edge with the beam past target
    a_wait_exit : assert property (@(posedge clk) disable iff (!rst_n_i)
        (reg_wr_o && wait_gate) |-> ($past(beam_ok, 4) && !$past(beam_ok, 5)))
    else begin
        $display("register write after a wait did not follow the beam reaching its target");
        $display("Test failed");
        $fatal(1);
    end

    // one write strobe followed by one idle cycle
    task automatic host_write(input logic [ADDR_W:0] addr, input logic [15:0] data);
        @(posedge clk);
        host_wr_i   <= 1'b1;
        host_addr_i <= addr;
        host_data_i <= data;
        @(posedge clk);
        host_wr_i <= 1'b0;
    endtask

    // even word carries data and odd word carries address and opcode
    task automatic load_move(input int idx, input logic [13:0] addr, input logic [15:0] data);
        host_write({ADDR_W'(idx), 1'b0}, data);
        host_write({ADDR_W'(idx), 1'b1}, {addr, copper_pkg::OP_MOVE});
    endtask

    task automatic load_wait(input int idx, input logic [13:0] v_pos, input logic [15:0] h_pos);
        host_write({ADDR_W'(idx), 1'b0}, h_pos);
        host_write({ADDR_W'(idx), 1'b1}, {v_pos, copper_pkg::OP_WAIT});
    endtask

    task automatic load_end(input int idx);
        host_write({ADDR_W'(idx), 1'b1}, {14'h0000, copper_pkg::OP_END});
    endtask

    // only the low REG_AW address bits reach the register port
    task automatic expect_write(input logic [13:0] addr, input logic [15:0] data);
        exp_addr_q[wr_ptr] = addr[REG_AW-1:0];
        exp_data_q[wr_ptr] = data;
        wr_ptr = wr_ptr + 1;
    endtask

    task automatic pulse_frame_start();
        @(posedge clk);
        frame_start_i <= 1'b1;
        started       <= 1'b1;
        @(posedge clk);
        frame_start_i <= 1'b0;
    endtask

    task automatic wait_drained();
        @(negedge clk);
        while (rd_ptr != wr_ptr) begin
            @(negedge clk);
        end
    endtask

    task automatic wait_idle();
        @(negedge clk);
        while (busy_o) begin
            @(negedge clk);
        end
    endtask

    initial begin
        logic [13:0] new_addr;
        logic [13:0] b_addr;
        logic [15:0] b_data;
        void'($urandom(32'hd7e9eb72));
        rst_n_i       = 1'b0;
        host_wr_i     = 1'b0;
        host_addr_i   = '0;
        host_data_i   = '0;
        frame_start_i = 1'b0;
        h_count_i     = '0;
        v_count_i     = '0;
        repeat (10) @(posedge clk);
        rst_n_i <= 1'b1;
        repeat (5) @(posedge clk);

        // empty memory decodes as END so no write and busy falls
        pulse_frame_start();
        wait_idle();

        // eight random moves and an END
        for (int i = 0; i < NUM_MOVES; i++) begin
            prog_addr[i] = 14'($urandom);
            prog_data[i] = 16'($urandom);
            load_move(i, prog_addr[i], prog_data[i]);
            expect_write(prog_addr[i], prog_data[i]);
        end
        load_end(NUM_MOVES);
        timing_chk <= 1'b1;
        pulse_frame_start();
        wait_drained();
        wait_idle();
        repeat (10) @(posedge clk);

        // same program again after END
        for (int i = 0; i < NUM_MOVES; i++) begin
            expect_write(prog_addr[i], prog_data[i]);
        end
        pulse_frame_start();
        wait_drained();
        wait_idle();
        timing_chk <= 1'b0;

        // wait for line 3 pixel 20 and one move while the beam sweeps upward
        wait_v = 14'd3;
        wait_h = 16'd20;
        load_wait(0, wait_v, wait_h);
        load_move(1, 14'h1a5, 16'hbeef);
        load_end(2);
        expect_write(14'h1a5, 16'hbeef);
        wait_gate <= 1'b1;
        pulse_frame_start();
        while (rd_ptr != wr_ptr) begin
            @(posedge clk);
            if (h_count_i == 16'd31) begin
                h_count_i <= '0;
                v_count_i <= v_count_i + 16'd1;
            end else begin
                h_count_i <= h_count_i + 16'd1;
            end
        end
        wait_idle();
        wait_gate <= 1'b0;

        // move, wait on an unreached line, move, END
        @(posedge clk);
        h_count_i <= '0;
        v_count_i <= '0;
        b_addr = 14'($urandom);
        b_data = 16'($urandom);
        load_move(0, prog_addr[0], prog_data[0]);
        load_wait(1, 14'd100, 16'd0);
        load_move(2, b_addr, b_data);
        load_end(3);
        expect_write(prog_addr[0], prog_data[0]);
        pulse_frame_start();
        wait_drained();
        repeat (5) @(posedge clk);

        // restart while waiting gives the first move again
        expect_write(prog_addr[0], prog_data[0]);
        pulse_frame_start();
        wait_drained();
        repeat (5) @(posedge clk);

        // new address for move 0 takes effect on the next run
        new_addr = prog_addr[0] ^ 14'h00ff;
        host_write({ADDR_W'(0), 1'b1}, {new_addr, copper_pkg::OP_MOVE});
        expect_write(new_addr, prog_data[0]);
        pulse_frame_start();
        wait_drained();

        // release the wait so the last move runs before END
        expect_write(b_addr, b_data);
        @(posedge clk);
        v_count_i <= 16'd200;
        wait_drained();
        wait_idle();
        repeat (10) @(posedge clk);

        $display("Test completed successfully");
        $finish;
    end

endmodule

// ==== project.f ====
src/copper_pkg.sv
src/copper_mem.sv
src/copper_engine.sv
src/copper_top.sv
verif/copper_tb.sv

// ==== Makefile ====
# Verilator build and run of the copper testbench

VERILATOR ?= verilator
TOP       ?= copper_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

# build, run, then search the log for the fail message
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Test failed" $(LOG); then \
		echo "simulation reported a failure, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "Test completed successfully" $(LOG); then \
		echo "simulation ended without finishing, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
